/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_digitizer_channel
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Simulation PASSED
FAIL_MSG   ?= Simulation FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
source/digitizer_pkg.sv
source/baseline_estimator.sv
source/hit_trigger.sv
source/add_header_footer.sv
source/digitizer_channel.sv
verif/frame_checker.sv
verif/tb_digitizer_channel.sv

/* source/add_header_footer.sv */
module add_header_footer #(
  parameter logic [digitizer_pkg::CHANNEL_ID_WIDTH-1:0] CHANNEL_ID = '0
) (
  input  logic                                           CLK,
  input  logic                                           RESETN,
  input  logic                                           triggered,
  input  logic [digitizer_pkg::TIME_STAMP_WIDTH-1:0]     time_stamp,
  input  logic [digitizer_pkg::THRESHOLD_WIDTH-1:0]      threshold_when_hit,
  input  logic [digitizer_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline_when_hit,
  input  digitizer_pkg::beat_u                           din,
  output logic [digitizer_pkg::DATA_WIDTH-1:0]           dout,
  output logic                                           adding_valid
);

  import digitizer_pkg::*;

  logic [HEADER_FOOTER_WIDTH-1:0] header;
  logic [HEADER_FOOTER_WIDTH-1:0] footer;
  logic [DATA_WIDTH-1:0]          header_beat;
  logic [DATA_WIDTH-1:0]          footer_beat;
  logic [DATA_WIDTH-1:0]          dout_d;

  logic delayed_triggered;
  logic delayed_delay_triggered;
  logic triggered_posedge;
  logic triggered_negedge;

  // ------------------------------------------------------------------------
  // Frame words
  // ------------------------------------------------------------------------
  // Header: id, channel, upper time stamp, zero pad
  assign header = {HEADER_ID,
                   CHANNEL_ID,
                   time_stamp[TIME_STAMP_WIDTH-1 -: FIRST_TIME_STAMP_WIDTH],
                   {(HEADER_FOOTER_WIDTH - HEAD_FOOT_ID_WIDTH - CHANNEL_ID_WIDTH
                     - FIRST_TIME_STAMP_WIDTH){1'b0}}};

  // Footer: baseline and threshold padded to a slot with ones
  assign footer = {{(SAMPLE_SLOT_WIDTH - ADC_RESOLUTION_WIDTH){1'b1}},
                   baseline_when_hit,
                   {(SAMPLE_SLOT_WIDTH - THRESHOLD_WIDTH){1'b1}},
                   threshold_when_hit,
                   1'b0,
                   time_stamp[LATER_TIME_STAMP_WIDTH-1:0],
                   FOOTER_ID};

  assign header_beat = {{HEADER_FOOTER_WIDTH{1'b1}}, header};
  assign footer_beat = {footer, {HEADER_FOOTER_WIDTH{1'b1}}};

  // ------------------------------------------------------------------------
  // Edge detect and output pipe
  // ------------------------------------------------------------------------
  assign triggered_posedge = triggered && !delayed_triggered;
  assign triggered_negedge = !triggered && delayed_triggered;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      delayed_triggered       <= 1'b0;
      delayed_delay_triggered <= 1'b0;
      adding_valid            <= 1'b0;
    end else begin
      delayed_triggered       <= triggered;
      delayed_delay_triggered <= delayed_triggered;
      adding_valid            <= delayed_triggered || delayed_delay_triggered;
    end
  end

  // Header and footer take the slot of the edge beat
  always_ff @(posedge CLK) begin
    if (triggered_posedge) begin
      dout_d <= header_beat;
    end else if (triggered_negedge) begin
      dout_d <= footer_beat;
    end else begin
      dout_d <= din.raw;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout <= '1;
    end else begin
      dout <= dout_d;
    end
  end

  a_valid_low_after_reset : assert property (
    @(posedge CLK) !RESETN |=> !adding_valid
  ) else $error("adding_valid high right after reset");

endmodule

/* source/baseline_estimator.sv */
module baseline_estimator (
  input  logic                                          CLK,
  input  logic                                          RESETN,
  input  digitizer_pkg::beat_u                          adc_data,
  input  logic                                          triggered,
  output digitizer_pkg::beat_u                          stage_beat,
  output logic [digitizer_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline
);

  import digitizer_pkg::*;

  logic [BEAT_SUM_WIDTH-1:0]       beat_sum;
  logic [ADC_RESOLUTION_WIDTH-1:0] beat_mean;

  // Sum of the registered beat, upper slot bits dropped
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      beat_sum = beat_sum + BEAT_SUM_WIDTH'(stage_beat.slot[i][ADC_RESOLUTION_WIDTH-1:0]);
    end
  end

  assign beat_mean = beat_sum[BEAT_SUM_WIDTH-1 -: ADC_RESOLUTION_WIDTH];  // Divide by 8

  always_ff @(posedge CLK) begin
    stage_beat <= adc_data;
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      baseline <= '0;
    end else if (!triggered) begin
      baseline <= beat_mean;  // Held while a window is open
    end
  end

  // Trigger comes back from the next stage, the freeze must hold across it
  a_baseline_frozen : assert property (
    @(posedge CLK) disable iff (!RESETN)
    triggered |=> $stable(baseline)
  ) else $error("baseline moved during trigger window");

endmodule

/* source/digitizer_channel.sv */
module digitizer_channel #(
  parameter logic [digitizer_pkg::CHANNEL_ID_WIDTH-1:0] CHANNEL_ID = '0
) (
  input  logic                                            CLK,
  input  logic                                            RESETN,
  input  logic [digitizer_pkg::DATA_WIDTH-1:0]            adc_data,
  input  logic signed [digitizer_pkg::THRESHOLD_WIDTH-1:0] threshold,
  output logic [digitizer_pkg::DATA_WIDTH-1:0]            dout,
  output logic                                            adding_valid
);

  import digitizer_pkg::*;

  beat_u                           stage_beat;
  beat_u                           trig_beat;
  logic [ADC_RESOLUTION_WIDTH-1:0] baseline;
  logic                            triggered;
  logic [TIME_STAMP_WIDTH-1:0]     time_stamp;
  logic [ADC_RESOLUTION_WIDTH-1:0] baseline_when_hit;
  logic [THRESHOLD_WIDTH-1:0]      threshold_when_hit;

  baseline_estimator u_baseline (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .adc_data   (adc_data),
    .triggered  (triggered),   // Freeze from stage 2
    .stage_beat (stage_beat),
    .baseline   (baseline)
  );

  hit_trigger u_trigger (
    .CLK                (CLK),
    .RESETN             (RESETN),
    .stage_beat         (stage_beat),
    .baseline           (baseline),
    .threshold          (threshold),
    .trig_beat          (trig_beat),
    .triggered          (triggered),
    .time_stamp         (time_stamp),
    .baseline_when_hit  (baseline_when_hit),
    .threshold_when_hit (threshold_when_hit)
  );

  add_header_footer #(
    .CHANNEL_ID (CHANNEL_ID)
  ) u_framer (
    .CLK                (CLK),
    .RESETN             (RESETN),
    .triggered          (triggered),
    .time_stamp         (time_stamp),
    .threshold_when_hit (threshold_when_hit),
    .baseline_when_hit  (baseline_when_hit),
    .din                (trig_beat),
    .dout               (dout),
    .adding_valid       (adding_valid)
  );

endmodule

/* source/digitizer_pkg.sv */
package digitizer_pkg;

  // ------------------------------------------------------------------------
  // Beat and sample geometry
  // ------------------------------------------------------------------------
  localparam int DATA_WIDTH           = 128;
  localparam int SAMPLES_PER_BEAT     = 8;
  localparam int SAMPLE_SLOT_WIDTH    = 16;
  localparam int ADC_RESOLUTION_WIDTH = 12;  // Low bits of each slot

  // Sum of one beat before the divide by SAMPLES_PER_BEAT
  localparam int BEAT_SUM_WIDTH = ADC_RESOLUTION_WIDTH + $clog2(SAMPLES_PER_BEAT);

  // ------------------------------------------------------------------------
  // Trigger
  // ------------------------------------------------------------------------
  localparam int THRESHOLD_WIDTH  = 13;  // Signed offset
  localparam int COMPARE_WIDTH    = THRESHOLD_WIDTH + 1;
  localparam int WINDOW_BEATS     = 8;
  localparam int HOLD_COUNT_WIDTH = $clog2(WINDOW_BEATS + 1);

  // ------------------------------------------------------------------------
  // Framing
  // ------------------------------------------------------------------------
  localparam int HEADER_FOOTER_WIDTH    = 64;
  localparam int TIME_STAMP_WIDTH       = 49;
  localparam int FIRST_TIME_STAMP_WIDTH = 26;  // Upper bits, in the header
  localparam int LATER_TIME_STAMP_WIDTH = TIME_STAMP_WIDTH - FIRST_TIME_STAMP_WIDTH;
  localparam int HEAD_FOOT_ID_WIDTH     = 8;
  localparam int CHANNEL_ID_WIDTH       = 4;

  localparam logic [HEAD_FOOT_ID_WIDTH-1:0] HEADER_ID = '1;
  localparam logic [HEAD_FOOT_ID_WIDTH-1:0] FOOTER_ID = 8'h0F;

  // One ADC beat, seen whole or as sample slots (slot 0 is the LSB end)
  typedef union packed {
    logic [DATA_WIDTH-1:0]                             raw;
    logic [SAMPLES_PER_BEAT-1:0][SAMPLE_SLOT_WIDTH-1:0] slot;
  } beat_u;

endpackage

/* source/hit_trigger.sv */
module hit_trigger (
  input  logic                                            CLK,
  input  logic                                            RESETN,
  input  digitizer_pkg::beat_u                            stage_beat,
  input  logic [digitizer_pkg::ADC_RESOLUTION_WIDTH-1:0]  baseline,
  input  logic signed [digitizer_pkg::THRESHOLD_WIDTH-1:0] threshold,
  output digitizer_pkg::beat_u                            trig_beat,
  output logic                                            triggered,
  output logic [digitizer_pkg::TIME_STAMP_WIDTH-1:0]      time_stamp,
  output logic [digitizer_pkg::ADC_RESOLUTION_WIDTH-1:0]  baseline_when_hit,
  output logic [digitizer_pkg::THRESHOLD_WIDTH-1:0]       threshold_when_hit
);

  import digitizer_pkg::*;

  logic signed [COMPARE_WIDTH-1:0] thr_ext;
  logic signed [COMPARE_WIDTH-1:0] base_ext;
  logic [SAMPLES_PER_BEAT-1:0]     hit_slot;
  logic                            hit;
  logic [HOLD_COUNT_WIDTH-1:0]     hold_cnt;

  // ------------------------------------------------------------------------
  // Hit detection, all slots in parallel
  // ------------------------------------------------------------------------
  assign thr_ext  = {threshold[THRESHOLD_WIDTH-1], threshold};
  assign base_ext = {{(COMPARE_WIDTH - ADC_RESOLUTION_WIDTH){1'b0}}, baseline};

  always_comb begin
    hit_slot = '0;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      // sample + threshold < baseline
      hit_slot[i] = ($signed({{(COMPARE_WIDTH - ADC_RESOLUTION_WIDTH){1'b0}},
                              stage_beat.slot[i][ADC_RESOLUTION_WIDTH-1:0]}) + thr_ext)
                    < base_ext;
    end
  end

  assign hit = |hit_slot;

  // ------------------------------------------------------------------------
  // Hold counter, trigger level and time stamp
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      hold_cnt   <= '0;
      triggered  <= 1'b0;
      time_stamp <= '0;
    end else begin
      time_stamp <= time_stamp + 1'b1;
      if (hit) begin
        hold_cnt <= HOLD_COUNT_WIDTH'(WINDOW_BEATS);  // Retrigger reloads
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      triggered <= hit || (hold_cnt > 1'b1);  // Next hold_cnt nonzero
    end
  end

  always_ff @(posedge CLK) begin
    trig_beat <= stage_beat;
    if (hit && !triggered) begin  // First hit of a window only
      baseline_when_hit  <= baseline;
      threshold_when_hit <= threshold;
    end
  end

  a_rise_after_hit : assert property (
    @(posedge CLK) disable iff (!RESETN)
    $rose(triggered) |-> $past(hit)
  ) else $error("triggered rose without a hit");

  a_hold_bound : assert property (
    @(posedge CLK) disable iff (!RESETN)
    hold_cnt <= HOLD_COUNT_WIDTH'(WINDOW_BEATS)
  ) else $error("hold count above window length");

endmodule

/* verif/frame_checker.sv */
module frame_checker #(
  parameter logic [digitizer_pkg::CHANNEL_ID_WIDTH-1:0] CHANNEL_ID = '0
) (
  input  logic                                             CLK,
  input  logic                                             RESETN,
  input  logic [digitizer_pkg::DATA_WIDTH-1:0]             adc_data,
  input  logic signed [digitizer_pkg::THRESHOLD_WIDTH-1:0] threshold,
  input  logic [digitizer_pkg::DATA_WIDTH-1:0]             dout,
  input  logic                                             adding_valid,
  input  int                                               phase,
  output int                                               data_errors,
  output int                                               valid_errors,
  output int                                               frames_seen
);
  timeunit 1ns;
  timeprecision 1ps;

  import digitizer_pkg::*;

  // --------------------------------------------------------------------------
  // Cycle model state
  // --------------------------------------------------------------------------
  logic [DATA_WIDTH-1:0]           m_in_beat   = '0;  // Beat under the hit rule
  logic [DATA_WIDTH-1:0]           m_trig_beat = '0;
  logic [ADC_RESOLUTION_WIDTH-1:0] m_baseline  = '0;
  int                              m_hold      = 0;
  logic                            m_trig      = 1'b0;
  logic                            m_trig_d    = 1'b0;
  logic [TIME_STAMP_WIDTH-1:0]     m_ts        = '0;
  logic [ADC_RESOLUTION_WIDTH-1:0] m_base_hit  = '0;
  logic [THRESHOLD_WIDTH-1:0]      m_thr_hit   = '0;
  logic [DATA_WIDTH-1:0]           m_pipe_word [2];   // [1] is the expected dout
  logic                            m_pipe_valid [2] = '{1'b0, 1'b0};
  int                              data_err_cnt = 0;
  int                              valid_err_cnt = 0;
  int                              frame_cnt = 0;
  int                              steps = 0;
  logic                            valid_prev = 1'b0;

  function automatic string phase_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "reset_quiet";
      2:       return "single_pulse";
      3:       return "retrigger";
      4:       return "baseline_freeze";
      5:       return "random_stream";
      default: return "drain";
    endcase
  endfunction

  // Steps the model one clock and leaves the expected outputs in the pipe
  function automatic void model_step(input logic [DATA_WIDTH-1:0] beat,
                                     input logic signed [THRESHOLD_WIDTH-1:0] thr,
                                     input logic rst_n);
    int                    sum;
    int                    sample;
    logic                  hit;
    logic [DATA_WIDTH-1:0] word;
    sum = 0;
    hit = 1'b0;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      sample = int'(m_in_beat[i*SAMPLE_SLOT_WIDTH +: ADC_RESOLUTION_WIDTH]);
      sum    = sum + sample;
      hit    = hit | (sample + int'(thr) < int'(m_baseline));
    end
    word = '1;
    if (m_trig && !m_trig_d) begin  // Header over the first window beat
      word[63:56] = HEADER_ID;
      word[55:52] = CHANNEL_ID;
      word[51:26] = m_ts[48:23];
      word[25:0]  = '0;
    end else if (!m_trig && m_trig_d) begin
      word[123:112] = m_base_hit;
      word[108:96]  = m_thr_hit;
      word[95]      = 1'b0;
      word[94:72]   = m_ts[22:0];
      word[71:64]   = FOOTER_ID;
    end else begin
      word = m_trig_beat;
    end
    m_pipe_word[1]  = rst_n ? m_pipe_word[0] : '1;
    m_pipe_valid[1] = rst_n && m_pipe_valid[0];
    m_pipe_word[0]  = word;
    m_pipe_valid[0] = rst_n && (m_trig || m_trig_d);  // Window plus the footer slot
    if (hit && !m_trig) begin
      m_base_hit = m_baseline;
      m_thr_hit  = thr;
    end
    m_trig_d    = rst_n && m_trig;
    m_trig_beat = m_in_beat;
    m_in_beat   = beat;
    if (!rst_n) begin
      m_baseline = '0;
      m_hold     = 0;
      m_trig     = 1'b0;
      m_ts       = '0;
    end else begin
      if (!m_trig) begin
        m_baseline = 12'(sum / SAMPLES_PER_BEAT);
      end
      m_hold = hit ? WINDOW_BEATS : ((m_hold > 0) ? m_hold - 1 : 0);
      m_trig = (m_hold > 0);
      m_ts   = m_ts + 1'b1;
    end
  endfunction

  always @(posedge CLK) begin
    if (steps > 0) begin
      if (dout !== m_pipe_word[1]) begin
        data_err_cnt++;
        $display("CHECK FAILED %s: dout expected %h, actual %h",
                 phase_name(phase), m_pipe_word[1], dout);
      end
      if (adding_valid !== m_pipe_valid[1]) begin
        valid_err_cnt++;
        $display("CHECK FAILED %s: adding_valid expected %b, actual %b",
                 phase_name(phase), m_pipe_valid[1], adding_valid);
      end
      if (adding_valid === 1'b1 && !valid_prev) begin
        frame_cnt++;
      end
      valid_prev = (adding_valid === 1'b1);
    end
    model_step(adc_data, threshold, RESETN);
    steps++;
  end

  assign data_errors  = data_err_cnt;
  assign valid_errors = valid_err_cnt;
  assign frames_seen  = frame_cnt;

endmodule

/* verif/tb_digitizer_channel.sv */
module tb_digitizer_channel;
  timeunit 1ns;
  timeprecision 1ps;

  import digitizer_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int QUIET_BEATS    = 40;
  localparam int PULSE_BEATS    = 31;
  localparam int RETRIG_BEATS   = 42;  // Three pulses spaced 5 and 6 beats
  localparam int FREEZE_BEATS   = 41;
  localparam int RANDOM_BEATS   = 300;
  localparam int DRAIN_BEATS    = 12;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + QUIET_BEATS + PULSE_BEATS + RETRIG_BEATS
                                  + FREEZE_BEATS + RANDOM_BEATS + DRAIN_BEATS + 64;

  logic                              CLK = 1'b0;
  logic                              RESETN;
  logic [DATA_WIDTH-1:0]             adc_data;
  logic signed [THRESHOLD_WIDTH-1:0] threshold;
  logic [DATA_WIDTH-1:0]             dout;
  logic                              adding_valid;
  int                                phase;
  int                                data_errors;
  int                                valid_errors;
  int                                frames_seen;
  int                                other_errors = 0;
  int                                cycle_count = 0;

  always #20 CLK = ~CLK;

  digitizer_channel #(.CHANNEL_ID(4'd5)) uut (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .adc_data     (adc_data),
    .threshold    (threshold),
    .dout         (dout),
    .adding_valid (adding_valid)
  );

  frame_checker #(.CHANNEL_ID(4'd5)) u_checker (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .adc_data     (adc_data),
    .threshold    (threshold),
    .dout         (dout),
    .adding_valid (adding_valid),
    .phase        (phase),
    .data_errors  (data_errors),
    .valid_errors (valid_errors),
    .frames_seen  (frames_seen)
  );

  // Eight samples at a level with optional noise and an optional low sample in one slot
  function automatic logic [DATA_WIDTH-1:0] build_beat(input int level, input bit noisy,
                                                       input int pulse_slot);
    beat_u b;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      b.slot[i] = noisy ? {4'($urandom), 12'(level + $urandom_range(0, 31))} : 16'(level);
    end
    if (pulse_slot >= 0) begin
      b.slot[pulse_slot] = noisy ? 16'($urandom_range(100, 700)) : 16'd600;
    end
    return b.raw;
  endfunction

  task automatic send_beats(input logic [DATA_WIDTH-1:0] beat, input int count);
    repeat (count) begin
      @(posedge CLK);
      adc_data <= beat;
    end
  endtask

  initial begin
    int level;
    void'($urandom(32'h7fe761ab));
    RESETN    = 1'b0;
    adc_data  = build_beat(1000, 1'b0, -1);
    threshold = 13'sd100;
    phase     = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RESETN <= 1'b1;
    phase  <= 1;
    send_beats(build_beat(1000, 1'b0, -1), QUIET_BEATS);
    phase <= 2;
    send_beats(build_beat(1000, 1'b0, 3), 1);
    send_beats(build_beat(1000, 1'b0, -1), PULSE_BEATS - 1);
    phase <= 3;
    send_beats(build_beat(1000, 1'b0, 0), 1);
    send_beats(build_beat(1000, 1'b0, -1), 4);
    send_beats(build_beat(1000, 1'b0, 7), 1);
    send_beats(build_beat(1000, 1'b0, -1), 5);
    send_beats(build_beat(1000, 1'b0, 2), 1);
    send_beats(build_beat(1000, 1'b0, -1), RETRIG_BEATS - 12);
    phase <= 4;
    send_beats(build_beat(1000, 1'b0, 6), 1);
    send_beats(build_beat(1400, 1'b0, -1), 2);  // Shift inside the window
    send_beats(build_beat(1100, 1'b0, -1), 1);  // Hits only if the baseline moved
    send_beats(build_beat(1400, 1'b0, -1), 16);
    send_beats(build_beat(1100, 1'b0, -1), 1);  // Hits once the baseline is at 1400
    send_beats(build_beat(1400, 1'b0, -1), FREEZE_BEATS - 21);
    @(negedge CLK);
    if (frames_seen != 4) begin
      $display("CHECK FAILED directed_frames: frame count expected 4, actual %0d",
               frames_seen);
      other_errors++;
    end
    phase <= 5;
    level = 1400;
    for (int n = 0; n < RANDOM_BEATS; n++) begin
      if (n % 50 == 0) begin
        level = int'($urandom_range(900, 1400));
      end
      @(posedge CLK);
      adc_data <= build_beat(level, 1'b1,
                             ($urandom_range(0, 15) == 0) ? int'($urandom_range(0, 7)) : -1);
      if (n % 60 == 30) begin
        threshold <= 13'($urandom_range(40, 220));
      end
    end
    phase <= 6;
    send_beats(build_beat(1000, 1'b0, -1), DRAIN_BEATS);
    @(negedge CLK);
    $display("Error counts: dout %0d, adding_valid %0d, other %0d",
             data_errors, valid_errors, other_errors);
    if (data_errors + valid_errors + other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule
